//--- common/ls_pkg.sv
`default_nettype none

package ls_pkg;

    parameter int XLEN   = 64;
    parameter int ADDR_W = 32;
    parameter int STRB_W = XLEN / 8;
    parameter int ID_W   = 2;

    parameter logic [2:0] AXI_SIZE_8B = 3'b011;       // 8 bytes per beat

    parameter logic [1:0] AXI_RESP_OKAY      = 2'b00;
    parameter logic [1:0] AXI_RESP_DECERR    = 2'b11;
    parameter logic [1:0] AXI_BURST_INCR     = 2'b01;
    parameter logic [2:0] AXI_PROT_DATA      = 3'b000; // unprivileged, secure, data
    parameter logic [3:0] AXI_CACHE_NONCACHE = 4'b0010;

    // requester side
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wmask;  // lsb aligned
        logic [2:0]        size;
    } ls_req_t;

    typedef struct packed {
        logic            rd_done;
        logic            wr_done;
        logic            err;
        logic [XLEN-1:0] rdata;
    } ls_rsp_t;

    // aw and ar share one layout
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic [2:0]        size;
        logic [7:0]        len;
        logic [1:0]        burst;
        logic [2:0]        prot;
        logic [3:0]        cache;
    } axi_ax_t;

    typedef struct packed {
        logic [XLEN-1:0]   data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [XLEN-1:0] data;
        logic [1:0]      resp;
        logic            last;
    } axi_r_t;

endpackage

`default_nettype wire

//--- ls_bridge/ls_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module ls_bridge #(
    parameter int PORT_ID = 0
) (
    input  logic            clock,
    input  logic            reset,

    input  ls_pkg::ls_req_t req_i,
    output ls_pkg::ls_rsp_t rsp_o,

    output logic            aw_valid_o,
    output ls_pkg::axi_ax_t aw_o,
    input  logic            aw_ready_i,

    output logic            w_valid_o,
    output ls_pkg::axi_w_t  w_o,
    input  logic            w_ready_i,

    input  logic            b_valid_i,
    input  ls_pkg::axi_b_t  b_i,
    output logic            b_ready_o,

    output logic            ar_valid_o,
    output ls_pkg::axi_ax_t ar_o,
    input  logic            ar_ready_i,

    input  logic            r_valid_i,
    input  ls_pkg::axi_r_t  r_i,
    output logic            r_ready_o
);

    // same encoding for both machines; in the write machine DONE also waits for b
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ADDR = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]                w_state_q, w_state_d;
    logic [1:0]                r_state_q, r_state_d;
    logic [ls_pkg::ADDR_W-1:0] addr_q;
    logic                      addr_same;
    logic                      wr_ok_q;     // b seen in DONE
    logic                      wr_err_q;
    logic                      rd_err_q;
    logic [ls_pkg::XLEN-1:0]   rdata_q;
    logic [5:0]                shift;
    logic                      wr_done, rd_done;

    assign addr_same = (req_i.addr == addr_q);
    assign shift     = {req_i.addr[2:0], 3'b000};

    always_comb begin
        w_state_d = w_state_q;
        case (w_state_q)
            ST_IDLE: if (req_i.wr) w_state_d = ST_ADDR;
            ST_ADDR: if (aw_ready_i) w_state_d = ST_DATA;
            ST_DATA: if (w_ready_i) w_state_d = ST_DONE;
            ST_DONE: begin
                if (wr_ok_q) begin              // never leave with b outstanding
                    if (!req_i.wr)
                        w_state_d = ST_IDLE;
                    else if (!addr_same)
                        w_state_d = ST_ADDR;    // new store, same request held
                end
            end
            default: w_state_d = ST_IDLE;
        endcase
    end

    always_comb begin
        r_state_d = r_state_q;
        case (r_state_q)
            ST_IDLE: if (req_i.rd) r_state_d = ST_ADDR;
            ST_ADDR: if (ar_ready_i) r_state_d = ST_DATA;
            ST_DATA: if (r_valid_i) r_state_d = ST_DONE;
            ST_DONE: begin
                if (!req_i.rd)
                    r_state_d = ST_IDLE;
                else if (!addr_same)
                    r_state_d = ST_ADDR;
            end
            default: r_state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state_q <= ST_IDLE;
            r_state_q <= ST_IDLE;
            wr_ok_q   <= 1'b0;
        end else begin
            w_state_q <= w_state_d;
            r_state_q <= r_state_d;
            if (w_state_q != ST_DONE)
                wr_ok_q <= 1'b0;
            else if (b_valid_i && b_ready_o)
                wr_ok_q <= 1'b1;
        end
    end

    // address for the same-address check, and response payload
    always_ff @(posedge clock) begin
        if (w_state_q == ST_ADDR || r_state_q == ST_ADDR)
            addr_q <= req_i.addr;
        if (b_valid_i && b_ready_o)
            wr_err_q <= (b_i.resp != ls_pkg::AXI_RESP_OKAY);
        if (r_valid_i && r_ready_o) begin
            rdata_q  <= r_i.data;
            rd_err_q <= (r_i.resp != ls_pkg::AXI_RESP_OKAY);
        end
    end

    assign aw_valid_o = (w_state_q == ST_ADDR);
    assign w_valid_o  = (w_state_q == ST_DATA);
    assign b_ready_o  = (w_state_q == ST_DONE) && !wr_ok_q;
    assign ar_valid_o = (r_state_q == ST_ADDR);
    assign r_ready_o  = (r_state_q == ST_DATA);

    assign aw_o = '{addr:  {req_i.addr[ls_pkg::ADDR_W-1:3], 3'b000},
                    id:    ls_pkg::ID_W'(PORT_ID),
                    size:  req_i.size,
                    len:   8'd0,                    // single beat
                    burst: ls_pkg::AXI_BURST_INCR,
                    prot:  ls_pkg::AXI_PROT_DATA,
                    cache: ls_pkg::AXI_CACHE_NONCACHE};

    assign ar_o = '{addr:  req_i.addr,
                    id:    ls_pkg::ID_W'(PORT_ID),
                    size:  ls_pkg::AXI_SIZE_8B,     // always the full word
                    len:   8'd0,
                    burst: ls_pkg::AXI_BURST_INCR,
                    prot:  ls_pkg::AXI_PROT_DATA,
                    cache: ls_pkg::AXI_CACHE_NONCACHE};

    // data and mask into lane position
    assign w_o = '{data: req_i.wdata << shift,
                   strb: req_i.wmask << req_i.addr[2:0],
                   last: w_valid_o};

    assign wr_done = (w_state_q == ST_DONE) && wr_ok_q && addr_same;
    assign rd_done = (r_state_q == ST_DONE) && addr_same;

    assign rsp_o = '{rd_done: rd_done,
                     wr_done: wr_done,
                     err:     (wr_done && wr_err_q) || (rd_done && rd_err_q),
                     rdata:   rd_done ? rdata_q : '0};

endmodule

`default_nettype wire

//--- src/axi_rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rr_arbiter #(
    parameter int N_PORTS = 2
) (
    input  logic                clock,
    input  logic                reset,

    input  logic [N_PORTS-1:0]  s_aw_valid_i,
    input  ls_pkg::axi_ax_t     s_aw_i [N_PORTS],
    output logic [N_PORTS-1:0]  s_aw_ready_o,
    input  logic [N_PORTS-1:0]  s_w_valid_i,
    input  ls_pkg::axi_w_t      s_w_i [N_PORTS],
    output logic [N_PORTS-1:0]  s_w_ready_o,
    output logic [N_PORTS-1:0]  s_b_valid_o,
    output ls_pkg::axi_b_t      s_b_o [N_PORTS],
    input  logic [N_PORTS-1:0]  s_b_ready_i,
    input  logic [N_PORTS-1:0]  s_ar_valid_i,
    input  ls_pkg::axi_ax_t     s_ar_i [N_PORTS],
    output logic [N_PORTS-1:0]  s_ar_ready_o,
    output logic [N_PORTS-1:0]  s_r_valid_o,
    output ls_pkg::axi_r_t      s_r_o [N_PORTS],
    input  logic [N_PORTS-1:0]  s_r_ready_i,

    output logic                m_aw_valid_o,
    output ls_pkg::axi_ax_t     m_aw_o,
    input  logic                m_aw_ready_i,
    output logic                m_w_valid_o,
    output ls_pkg::axi_w_t      m_w_o,
    input  logic                m_w_ready_i,
    input  logic                m_b_valid_i,
    input  ls_pkg::axi_b_t      m_b_i,
    output logic                m_b_ready_o,
    output logic                m_ar_valid_o,
    output ls_pkg::axi_ax_t     m_ar_o,
    input  logic                m_ar_ready_i,
    input  logic                m_r_valid_i,
    input  ls_pkg::axi_r_t      m_r_i,
    output logic                m_r_ready_o
);

    localparam int GW = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    logic          busy_q;
    logic          is_wr_q;      // kind of the granted transaction
    logic [GW-1:0] grant_q;
    logic [GW-1:0] last_q;       // last winner
    logic          pick_valid, pick_wr;
    logic [GW-1:0] pick;
    logic          wr_grant, rd_grant;
    logic          b_fire, r_fire;

    // round robin, nearest port after the last winner
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick       = last_q;
        pick_wr    = 1'b0;
        for (int k = N_PORTS; k >= 1; k--) begin
            idx = (int'(last_q) + k) % N_PORTS;
            if (s_aw_valid_i[idx] || s_ar_valid_i[idx]) begin
                pick_valid = 1'b1;
                pick       = GW'(idx);
                pick_wr    = s_aw_valid_i[idx];   // write wins on the same port
            end
        end
    end

    assign wr_grant = busy_q && is_wr_q;
    assign rd_grant = busy_q && !is_wr_q;
    assign b_fire   = wr_grant && m_b_valid_i && m_b_ready_o;
    assign r_fire   = rd_grant && m_r_valid_i && m_r_ready_o && m_r_i.last;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            busy_q  <= 1'b0;
            is_wr_q <= 1'b0;
            grant_q <= '0;
            last_q  <= GW'(N_PORTS - 1);         // port 0 goes first
        end else if (!busy_q) begin
            if (pick_valid) begin
                busy_q  <= 1'b1;
                is_wr_q <= pick_wr;
                grant_q <= pick;
                last_q  <= pick;
            end
        end else if (b_fire || r_fire) begin
            busy_q <= 1'b0;
        end
    end

    assign m_aw_valid_o = wr_grant && s_aw_valid_i[grant_q];
    assign m_aw_o       = s_aw_i[grant_q];
    assign m_w_valid_o  = wr_grant && s_w_valid_i[grant_q];
    assign m_w_o        = s_w_i[grant_q];
    assign m_ar_valid_o = rd_grant && s_ar_valid_i[grant_q];
    assign m_ar_o       = s_ar_i[grant_q];

    // readies to the granted port only, responses back by id
    always_comb begin
        m_b_ready_o = 1'b0;
        m_r_ready_o = 1'b0;
        for (int i = 0; i < N_PORTS; i++) begin
            s_aw_ready_o[i] = wr_grant && (grant_q == GW'(i)) && m_aw_ready_i;
            s_w_ready_o[i]  = wr_grant && (grant_q == GW'(i)) && m_w_ready_i;
            s_ar_ready_o[i] = rd_grant && (grant_q == GW'(i)) && m_ar_ready_i;
            s_b_valid_o[i]  = m_b_valid_i && (m_b_i.id == ls_pkg::ID_W'(i));
            s_r_valid_o[i]  = m_r_valid_i && (m_r_i.id == ls_pkg::ID_W'(i));
            s_b_o[i]        = m_b_i;
            s_r_o[i]        = m_r_i;
            if (m_b_i.id == ls_pkg::ID_W'(i))
                m_b_ready_o = s_b_ready_i[i];
            if (m_r_i.id == ls_pkg::ID_W'(i))
                m_r_ready_o = s_r_ready_i[i];
        end
    end

endmodule

`default_nettype wire

//--- src/axi_ram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram #(
    parameter int MEM_WORDS = 256,
    parameter int ID_W      = 2
) (
    input  logic            clock,
    input  logic            reset,

    input  logic            aw_valid_i,
    input  ls_pkg::axi_ax_t aw_i,
    output logic            aw_ready_o,
    input  logic            w_valid_i,
    input  ls_pkg::axi_w_t  w_i,
    output logic            w_ready_o,
    output logic            b_valid_o,
    output ls_pkg::axi_b_t  b_o,
    input  logic            b_ready_i,
    input  logic            ar_valid_i,
    input  ls_pkg::axi_ax_t ar_i,
    output logic            ar_ready_o,
    output logic            r_valid_o,
    output ls_pkg::axi_r_t  r_o,
    input  logic            r_ready_i
);

    localparam int IW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int WW = ls_pkg::ADDR_W - 3;          // word index width

    localparam logic [1:0] W_IDLE = 2'd0;
    localparam logic [1:0] W_DATA = 2'd1;
    localparam logic [1:0] W_RESP = 2'd2;

    logic [ls_pkg::XLEN-1:0] mem [MEM_WORDS];

    logic [1:0]              w_state_q;
    logic [WW-1:0]           w_idx_q;
    logic                    w_err_q;
    logic [ID_W-1:0]         b_id_q;
    logic                    r_busy_q;
    logic [ID_W-1:0]         r_id_q;
    logic                    r_err_q;
    logic [ls_pkg::XLEN-1:0] r_data_q;
    logic [WW-1:0]           ar_idx;

    assign ar_idx = ar_i.addr[ls_pkg::ADDR_W-1:3];

    // write sequencer
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            w_state_q <= W_IDLE;
        end else begin
            case (w_state_q)
                W_IDLE: if (aw_valid_i) w_state_q <= W_DATA;
                W_DATA: if (w_valid_i) w_state_q <= W_RESP;
                W_RESP: if (b_ready_i) w_state_q <= W_IDLE;
                default: w_state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (w_state_q == W_IDLE && aw_valid_i) begin
            w_idx_q <= aw_i.addr[ls_pkg::ADDR_W-1:3];
            w_err_q <= (aw_i.addr[ls_pkg::ADDR_W-1:3] >= WW'(MEM_WORDS));
            b_id_q  <= aw_i.id;
        end
        if (w_state_q == W_DATA && w_valid_i && !w_err_q) begin
            for (int b = 0; b < ls_pkg::STRB_W; b++) begin
                if (w_i.strb[b])
                    mem[w_idx_q[IW-1:0]][b*8 +: 8] <= w_i.data[b*8 +: 8];
            end
        end
    end

    assign aw_ready_o = (w_state_q == W_IDLE);
    assign w_ready_o  = (w_state_q == W_DATA);
    assign b_valid_o  = (w_state_q == W_RESP);
    assign b_o = '{id:   b_id_q,
                   resp: w_err_q ? ls_pkg::AXI_RESP_DECERR : ls_pkg::AXI_RESP_OKAY};

    // read sequencer, data sampled at the ar handshake
    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            r_busy_q <= 1'b0;
        else if (!r_busy_q && ar_valid_i)
            r_busy_q <= 1'b1;
        else if (r_busy_q && r_ready_i)
            r_busy_q <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (!r_busy_q && ar_valid_i) begin
            r_id_q   <= ar_i.id;
            r_err_q  <= (ar_idx >= WW'(MEM_WORDS));
            r_data_q <= (ar_idx >= WW'(MEM_WORDS)) ? '0 : mem[ar_idx[IW-1:0]];
        end
    end

    assign ar_ready_o = !r_busy_q;
    assign r_valid_o  = r_busy_q;
    assign r_o = '{id:   r_id_q,
                   data: r_data_q,
                   resp: r_err_q ? ls_pkg::AXI_RESP_DECERR : ls_pkg::AXI_RESP_OKAY,
                   last: 1'b1};

endmodule

`default_nettype wire

//--- src/ls_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module ls_mem_top #(
    parameter int N_PORTS   = 2,
    parameter int MEM_WORDS = 256
) (
    input  logic            clock,
    input  logic            reset,
    input  ls_pkg::ls_req_t req_i [N_PORTS],
    output ls_pkg::ls_rsp_t rsp_o [N_PORTS]
);

    // bridge side, one element per port
    wire [N_PORTS-1:0]    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    wire [N_PORTS-1:0]    ar_valid, ar_ready, r_valid, r_ready;
    wire ls_pkg::axi_ax_t aw [N_PORTS];
    wire ls_pkg::axi_ax_t ar [N_PORTS];
    wire ls_pkg::axi_w_t  w  [N_PORTS];
    wire ls_pkg::axi_b_t  b  [N_PORTS];
    wire ls_pkg::axi_r_t  r  [N_PORTS];

    // shared bus into the ram
    wire                  m_aw_valid, m_aw_ready, m_w_valid, m_w_ready, m_b_valid, m_b_ready;
    wire                  m_ar_valid, m_ar_ready, m_r_valid, m_r_ready;
    wire ls_pkg::axi_ax_t m_aw, m_ar;
    wire ls_pkg::axi_w_t  m_w;
    wire ls_pkg::axi_b_t  m_b;
    wire ls_pkg::axi_r_t  m_r;

    for (genvar i = 0; i < N_PORTS; i++) begin : g_bridge
        ls_bridge #(.PORT_ID(i)) bridge_i (
            .clock(clock), .reset(reset), .req_i(req_i[i]), .rsp_o(rsp_o[i]),
            .aw_valid_o(aw_valid[i]), .aw_o(aw[i]), .aw_ready_i(aw_ready[i]),
            .w_valid_o(w_valid[i]), .w_o(w[i]), .w_ready_i(w_ready[i]),
            .b_valid_i(b_valid[i]), .b_i(b[i]), .b_ready_o(b_ready[i]),
            .ar_valid_o(ar_valid[i]), .ar_o(ar[i]), .ar_ready_i(ar_ready[i]),
            .r_valid_i(r_valid[i]), .r_i(r[i]), .r_ready_o(r_ready[i])
        );
    end

    axi_rr_arbiter #(.N_PORTS(N_PORTS)) arbiter_i (
        .clock(clock), .reset(reset),
        .s_aw_valid_i(aw_valid), .s_aw_i(aw), .s_aw_ready_o(aw_ready),
        .s_w_valid_i(w_valid), .s_w_i(w), .s_w_ready_o(w_ready),
        .s_b_valid_o(b_valid), .s_b_o(b), .s_b_ready_i(b_ready),
        .s_ar_valid_i(ar_valid), .s_ar_i(ar), .s_ar_ready_o(ar_ready),
        .s_r_valid_o(r_valid), .s_r_o(r), .s_r_ready_i(r_ready),
        .m_aw_valid_o(m_aw_valid), .m_aw_o(m_aw), .m_aw_ready_i(m_aw_ready),
        .m_w_valid_o(m_w_valid), .m_w_o(m_w), .m_w_ready_i(m_w_ready),
        .m_b_valid_i(m_b_valid), .m_b_i(m_b), .m_b_ready_o(m_b_ready),
        .m_ar_valid_o(m_ar_valid), .m_ar_o(m_ar), .m_ar_ready_i(m_ar_ready),
        .m_r_valid_i(m_r_valid), .m_r_i(m_r), .m_r_ready_o(m_r_ready)
    );

    axi_ram #(.MEM_WORDS(MEM_WORDS), .ID_W(ls_pkg::ID_W)) ram_i (
        .clock(clock), .reset(reset),
        .aw_valid_i(m_aw_valid), .aw_i(m_aw), .aw_ready_o(m_aw_ready),
        .w_valid_i(m_w_valid), .w_i(m_w), .w_ready_o(m_w_ready),
        .b_valid_o(m_b_valid), .b_o(m_b), .b_ready_i(m_b_ready),
        .ar_valid_i(m_ar_valid), .ar_i(m_ar), .ar_ready_o(m_ar_ready),
        .r_valid_o(m_r_valid), .r_o(m_r), .r_ready_i(m_r_ready)
    );

endmodule

`default_nettype wire

//--- bench/tb_ls_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ls_mem_top;

    localparam int N_PORTS   = 2;
    localparam int MEM_WORDS = 256;
    localparam int N_TRANS   = 88;                    // sum over all tests
    localparam int TIMEOUT   = N_TRANS * 20 + 16;
    localparam int WAIT_MAX  = 40;
    localparam int LAT_MAX   = 12;                    // own transaction plus one other

    logic            clock;
    logic            reset;
    ls_pkg::ls_req_t req [N_PORTS];
    ls_pkg::ls_rsp_t rsp [N_PORTS];

    logic [7:0]  ref_mem [MEM_WORDS*8];              // byte level reference
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          cycle_cnt;

    ls_mem_top #(.N_PORTS(N_PORTS), .MEM_WORDS(MEM_WORDS)) dut_i (
        .clock(clock), .reset(reset), .req_i(req), .rsp_o(rsp)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            $display("timeout after %0d cycles, errors %0d of %0d checks",
                     cycle_cnt, errors, checks);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift_next();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // mask is lsb aligned, bytes past the word end drop out
    task automatic model_store(input logic [31:0] addr, input logic [63:0] data,
                               input logic [7:0] mask);
        int base;
        int off;
        base = int'({addr[31:3], 3'b000});
        off  = int'(addr[2:0]);
        for (int b = 0; b + off < 8; b++) begin
            if (mask[b])
                ref_mem[base + b + off] = data[b*8 +: 8];
        end
    endtask

    function automatic logic [63:0] model_word(input logic [31:0] addr);
        logic [63:0] word;
        int          base;
        base = int'({addr[31:3], 3'b000});
        for (int b = 0; b < 8; b++)
            word[b*8 +: 8] = ref_mem[base + b];
        return word;
    endfunction

    task automatic wait_done(input int port, input logic is_wr, output logic done,
                             output int cycles);
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < WAIT_MAX) begin
            @(negedge clock);                         // sample between edges
            cycles++;
            done = is_wr ? rsp[port].wr_done : rsp[port].rd_done;
        end
        assert (done) else begin
            errors++;
            $display("port %0d: request never completed", port);
        end
    endtask

    // one request, held until done, then dropped
    task automatic access(input int port, input logic is_wr, input logic [31:0] addr,
                          input logic [63:0] wdata, input logic [7:0] mask,
                          output logic [63:0] rdata, output logic err);
        logic done;
        int   cycles;
        @(posedge clock);
        #2;
        req[port].rd    = !is_wr;
        req[port].wr    = is_wr;
        req[port].addr  = addr;
        req[port].wdata = wdata;
        req[port].wmask = mask;
        req[port].size  = ls_pkg::AXI_SIZE_8B;
        wait_done(port, is_wr, done, cycles);
        rdata = rsp[port].rdata;
        err   = rsp[port].err;
        assert (cycles <= LAT_MAX) else begin
            errors++;
            $display("port %0d: waited %0d cycles, more than one other transaction",
                     port, cycles);
        end
        @(posedge clock);
        #2;
        req[port].rd = 1'b0;
        req[port].wr = 1'b0;
    endtask

    task automatic store_chk(input int port, input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] mask, input logic exp_err);
        logic [63:0] rdata;
        logic        err;
        access(port, 1'b1, addr, data, mask, rdata, err);
        check_val("err", 64'(err), 64'(exp_err));
        check_val("rdata", rdata, 64'd0);              // no load done, so zero
        if (!exp_err)
            model_store(addr, data, mask);
    endtask

    task automatic load_chk(input int port, input logic [31:0] addr, input logic exp_err);
        logic [63:0] rdata;
        logic        err;
        access(port, 1'b0, addr, 64'd0, 8'h00, rdata, err);
        check_val("err", 64'(err), 64'(exp_err));
        check_val("rdata", rdata, exp_err ? 64'd0 : model_word(addr));
    endtask

    task automatic test_full_word();
        store_chk(0, 32'h40, 64'hdead_beef_0bad_f00d, 8'hff, 1'b0);
        load_chk(0, 32'h40, 1'b0);
    endtask

    task automatic test_masked_store();
        for (int off = 1; off < 8; off++) begin
            store_chk(0, 32'h80, {xorshift_next(), xorshift_next()}, 8'hff, 1'b0);
            store_chk(0, 32'h80 + off, {xorshift_next(), xorshift_next()},
                      8'(xorshift_next()), 1'b0);
            load_chk(0, 32'h80, 1'b0);
        end
    endtask

    task automatic test_two_ports();
        fork
            store_chk(0, 32'h100, 64'h1111_2222_3333_4444, 8'hff, 1'b0);
            store_chk(1, 32'h108, 64'h5555_6666_7777_8888, 8'hff, 1'b0);
        join
        fork
            load_chk(0, 32'h108, 1'b0);                // crossed on purpose
            load_chk(1, 32'h100, 1'b0);
        join
    endtask

    task automatic test_out_of_range();
        // low index bits match the word at 0x40
        store_chk(1, MEM_WORDS * 8 + 32'h40, 64'hffff_ffff_ffff_ffff, 8'hff, 1'b1);
        load_chk(1, MEM_WORDS * 8 + 32'h1000, 1'b1);
        load_chk(0, 32'h40, 1'b0);                     // word from the first test
    endtask

    task automatic test_addr_change();
        logic done;
        int   cycles;
        @(posedge clock);
        #2;
        req[0].rd   = 1'b1;
        req[0].addr = 32'h40;
        wait_done(0, 1'b0, done, cycles);
        check_val("rdata", rsp[0].rdata, model_word(32'h40));
        @(negedge clock);
        check_val("rd_done", 64'(rsp[0].rd_done), 64'd1);   // held with same address
        @(posedge clock);
        #2;
        req[0].addr = 32'h100;                         // rd stays high
        @(negedge clock);
        check_val("rd_done", 64'(rsp[0].rd_done), 64'd0);
        wait_done(0, 1'b0, done, cycles);
        check_val("rdata", rsp[0].rdata, model_word(32'h100));
        @(posedge clock);
        #2;
        req[0].rd = 1'b0;
    endtask

    task automatic test_random();
        logic [31:0] r;
        logic [31:0] addr;
        for (int i = 0; i < 16; i++)
            store_chk(i % 2, i * 8, {xorshift_next(), xorshift_next()}, 8'hff, 1'b0);
        for (int n = 0; n < 40; n++) begin
            r    = xorshift_next();
            addr = {25'd0, r[7:1]} & 32'h7f;           // word 0 to 15, any byte
            if (r[8])
                store_chk(r[0], addr, {xorshift_next(), xorshift_next()},
                          8'(xorshift_next()), 1'b0);
            else
                load_chk(r[0], addr, 1'b0);
        end
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        cycle_cnt = 0;
        rng_state = 32'hc54b56e5;
        reset     = 1'b0;
        for (int i = 0; i < N_PORTS; i++)
            req[i] = '0;
        repeat (16) @(posedge clock);
        #2;
        reset = 1'b1;

        test_full_word();
        test_masked_store();
        test_two_ports();
        test_out_of_range();
        test_addr_change();
        test_random();

        repeat (2) @(posedge clock);
        $display("errors %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
common/ls_pkg.sv
ls_bridge/ls_bridge.sv
src/axi_rr_arbiter.sv
src/axi_ram.sv
src/ls_mem_top.sv
bench/tb_ls_mem_top.sv

//--- Bender.yml
package:
  name: ls_mem

sources:
  - common/ls_pkg.sv
  - ls_bridge/ls_bridge.sv
  - src/axi_rr_arbiter.sv
  - src/axi_ram.sv
  - src/ls_mem_top.sv
  - target: test
    files:
      - bench/tb_ls_mem_top.sv
